// File: ball_gen.sv
`default_nettype none

module ball_gen (
   input  logic clk,
   input  logic reset,
   scan_if.sink scan,
   output logic ball_on
);

   vga_timing_pkg::coord_t ball_x;
   vga_timing_pkg::coord_t ball_y;
   gfx_pkg::dir_e          dir_x;
   gfx_pkg::dir_e          dir_y;
   vga_timing_pkg::coord_t dx;
   vga_timing_pkg::coord_t dy;
   logic [7:0]             rom_row;
   logic                   in_rect;

   // ----------------------------------------------------------------------
   // one axis step with bounce at 0 and max
   // ----------------------------------------------------------------------
   function automatic vga_timing_pkg::coord_t step_pos(
      input vga_timing_pkg::coord_t pos,
      input gfx_pkg::dir_e          dir,
      input vga_timing_pkg::coord_t max);
      if (dir == gfx_pkg::DIR_DEC)
         step_pos = (pos == '0) ? 10'd1 : pos - 10'd1;
      else
         step_pos = (pos == max) ? max - 10'd1 : pos + 10'd1;
   endfunction

   function automatic gfx_pkg::dir_e step_dir(
      input vga_timing_pkg::coord_t pos,
      input gfx_pkg::dir_e          dir,
      input vga_timing_pkg::coord_t max);
      step_dir = dir;
      // flip only when sitting on the edge it heads for
      if (dir == gfx_pkg::DIR_DEC && pos == '0)
         step_dir = gfx_pkg::DIR_INC;
      else if (dir == gfx_pkg::DIR_INC && pos == max)
         step_dir = gfx_pkg::DIR_DEC;
   endfunction

   // position and direction, updated once per frame
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         ball_x <= gfx_pkg::BALL_X0;
         ball_y <= gfx_pkg::BALL_Y0;
         dir_x  <= gfx_pkg::DIR_INC;
         dir_y  <= gfx_pkg::DIR_DEC;
      end
      else if (scan.refr_tick)
      begin
         ball_x <= step_pos(ball_x, dir_x, gfx_pkg::BALL_X_MAX);
         ball_y <= step_pos(ball_y, dir_y, gfx_pkg::BALL_Y_MAX);
         dir_x  <= step_dir(ball_x, dir_x, gfx_pkg::BALL_X_MAX);
         dir_y  <= step_dir(ball_y, dir_y, gfx_pkg::BALL_Y_MAX);
      end
   end

   // ----------------------------------------------------------------------
   // round ball image
   // ----------------------------------------------------------------------
   assign in_rect = (scan.pix_x >= ball_x) && (scan.pix_x < ball_x + gfx_pkg::BALL_SIZE) &&
                    (scan.pix_y >= ball_y) && (scan.pix_y < ball_y + gfx_pkg::BALL_SIZE);

   assign dx = scan.pix_x - ball_x;
   assign dy = scan.pix_y - ball_y;

   always_comb
   begin
      case (dy[2:0])
         3'd0, 3'd7: rom_row = 8'h3C;
         3'd1, 3'd6: rom_row = 8'h7E;
         default:    rom_row = 8'hFF;
      endcase
   end

   // bit 7 is the leftmost column
   assign ball_on = in_rect & rom_row[3'd7 - dx[2:0]];

endmodule

`default_nettype wire

// File: compile.f
vga_timing_pkg.sv
gfx_pkg.sv
scan_if.sv
vga_scan_gen.sv
logo_gen.sv
ball_gen.sv
pixel_mixer.sv
sprite_display_top.sv
tb_clock_gen.sv
sprite_display_assert.sv
sprite_display_tb.sv

// File: gfx_pkg.sv
`default_nettype none

package gfx_pkg;

   // 3-bit colour, red in bit 2, green in bit 1, blue in bit 0
   typedef logic [2:0] rgb_t;

   localparam rgb_t COLOR_LOGO  = 3'b101;
   localparam rgb_t COLOR_BALL  = 3'b110;
   localparam rgb_t COLOR_BACK  = 3'b001;
   localparam rgb_t COLOR_BLANK = 3'b000;

   // ----------------------------------------------------------------------
   // object placement and size
   // ----------------------------------------------------------------------
   // logo, top-left corner and bitmap size
   localparam vga_timing_pkg::coord_t LOGO_X = 10'd300;
   localparam vga_timing_pkg::coord_t LOGO_Y = 10'd10;
   localparam vga_timing_pkg::coord_t LOGO_W = 10'd32;
   localparam vga_timing_pkg::coord_t LOGO_H = 10'd16;

   // ball is square
   localparam vga_timing_pkg::coord_t BALL_SIZE  = 10'd8;
   // start corner after reset
   localparam vga_timing_pkg::coord_t BALL_X0    = 10'd320;
   localparam vga_timing_pkg::coord_t BALL_Y0    = 10'd4;
   // highest top-left corner that keeps the ball on screen
   localparam vga_timing_pkg::coord_t BALL_X_MAX = 10'd632;
   localparam vga_timing_pkg::coord_t BALL_Y_MAX = 10'd472;

   // layer picked by the mixer
   typedef enum logic [1:0] {LAYER_BLANK, LAYER_LOGO, LAYER_BALL, LAYER_BACK} layer_e;

   // per-axis ball direction
   typedef enum logic {DIR_INC, DIR_DEC} dir_e;

endpackage

`default_nettype wire

// File: logo_gen.sv
`default_nettype none

module logo_gen (
   scan_if.sink scan,
   output logic logo_on
);

   vga_timing_pkg::coord_t dx;
   vga_timing_pkg::coord_t dy;
   logic [3:0]             rom_addr;
   logic [4:0]             rom_col;
   logic [31:0]            rom_data;
   logic                   rom_bit;
   logic                   in_rect;

   // ----------------------------------------------------------------------
   // fixed rectangle hit
   // ----------------------------------------------------------------------
   assign in_rect = (scan.pix_x >= gfx_pkg::LOGO_X) &&
                    (scan.pix_x < gfx_pkg::LOGO_X + gfx_pkg::LOGO_W) &&
                    (scan.pix_y >= gfx_pkg::LOGO_Y) &&
                    (scan.pix_y < gfx_pkg::LOGO_Y + gfx_pkg::LOGO_H);

   // offsets inside the logo, only meaningful when in_rect
   assign dx = scan.pix_x - gfx_pkg::LOGO_X;
   assign dy = scan.pix_y - gfx_pkg::LOGO_Y;

   // 16 rows x 32 columns
   assign rom_addr = dy[3:0];
   assign rom_col  = dx[4:0];

   // ----------------------------------------------------------------------
   // zero digit bitmap
   // ----------------------------------------------------------------------
   // bit n of a row is column offset n
   // shape is left-right symmetric
   always_comb
   begin
      case (rom_addr)
         4'h0:    rom_data = 32'h0003_C000;
         4'h1:    rom_data = 32'h000F_F000;
         4'h2:    rom_data = 32'h001E_7800;
         4'h3:    rom_data = 32'h0038_1C00;
         4'h4:    rom_data = 32'h0030_0C00;
         4'h5:    rom_data = 32'h0070_0E00;
         // straight sides of the digit
         4'h6,
         4'h7,
         4'h8,
         4'h9:    rom_data = 32'h0060_0600;
         4'hA:    rom_data = 32'h0070_0E00;
         4'hB:    rom_data = 32'h0030_0C00;
         4'hC:    rom_data = 32'h0038_1C00;
         4'hD:    rom_data = 32'h001E_7800;
         4'hE:    rom_data = 32'h000F_F000;
         default: rom_data = 32'h0003_C000;
      endcase
   end

   assign rom_bit = rom_data[rom_col];

   // lit only inside the rectangle and on a set bit
   assign logo_on = in_rect & rom_bit;

endmodule

`default_nettype wire

// File: pixel_mixer.sv
`default_nettype none

module pixel_mixer (
   input  logic         clk,
   input  logic         reset,
   scan_if.sink         scan,
   input  logic         logo_on,
   input  logic         ball_on,
   input  logic         hsync_raw,
   input  logic         vsync_raw,
   output gfx_pkg::rgb_t rgb,
   output logic         hsync,
   output logic         vsync
);

   gfx_pkg::layer_e layer;
   gfx_pkg::rgb_t   rgb_next;

   // priority, logo over ball over background
   always_comb
   begin
      if (!scan.video_on)
         layer = gfx_pkg::LAYER_BLANK;
      else if (logo_on)
         layer = gfx_pkg::LAYER_LOGO;
      else if (ball_on)
         layer = gfx_pkg::LAYER_BALL;
      else
         layer = gfx_pkg::LAYER_BACK;
   end

   always_comb
   begin
      case (layer)
         gfx_pkg::LAYER_LOGO: rgb_next = gfx_pkg::COLOR_LOGO;
         gfx_pkg::LAYER_BALL: rgb_next = gfx_pkg::COLOR_BALL;
         gfx_pkg::LAYER_BACK: rgb_next = gfx_pkg::COLOR_BACK;
         default:             rgb_next = gfx_pkg::COLOR_BLANK;
      endcase
   end

   // colour and syncs leave together, one clock after the scan position
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         rgb   <= gfx_pkg::COLOR_BLANK;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end
      else
      begin
         rgb   <= rgb_next;
         hsync <= hsync_raw;
         vsync <= vsync_raw;
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module sprite_display_tb \
   -f compile.f -o sprite_display_sim &&
./obj_dir/sprite_display_sim | tee /dev/stderr | grep "sim passed" > /dev/null &&
echo "simulation PASS" ||
{ echo "simulation FAIL"; exit 1; }

// File: scan_if.sv
`default_nettype none

// scan position and strobes, one producer and several readers
interface scan_if;

   logic                   video_on;
   vga_timing_pkg::coord_t pix_x;
   vga_timing_pkg::coord_t pix_y;
   // one clock per frame, below the visible area
   logic                   refr_tick;

   modport source (output video_on, output pix_x, output pix_y, output refr_tick);

   modport sink (input video_on, input pix_x, input pix_y, input refr_tick);

endinterface

`default_nettype wire

// File: sprite_display_assert.sv
`default_nettype none

module sprite_display_assert (
   input logic          clk,
   input logic          reset,
   input logic          hsync,
   input logic          vsync,
   input gfx_pkg::rgb_t rgb
);

   // length of the current low pulse on each sync
   int   h_low_cnt;
   int   v_low_cnt;
   // sticky flags, one per property
   logic hs_bad  = 1'b0;
   logic vs_bad  = 1'b0;
   logic rgb_bad = 1'b0;
   logic rst_bad = 1'b0;
   logic any_failed;

   assign any_failed = hs_bad | vs_bad | rgb_bad | rst_bad;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_low_cnt <= 0;
         v_low_cnt <= 0;
      end
      else
      begin
         h_low_cnt <= hsync ? 0 : h_low_cnt + 1;
         v_low_cnt <= vsync ? 0 : v_low_cnt + 1;
      end
   end

   // ----------------------------------------------------------------------
   // sync pulse widths
   // ----------------------------------------------------------------------
   // 96 pixel clocks per line pulse
   hsync_width: assert property (@(posedge clk) disable iff (reset)
      $rose(hsync) |-> h_low_cnt == 96)
   else
   begin
      $error("hsync low pulse is not 96 cycles long");
      hs_bad = 1'b1;
   end

   // two full lines per frame pulse
   vsync_width: assert property (@(posedge clk) disable iff (reset)
      $rose(vsync) |-> v_low_cnt == 1600)
   else
   begin
      $error("vsync low pulse is not 1600 cycles long");
      vs_bad = 1'b1;
   end

   // colour dark during any sync pulse
   rgb_dark_in_sync: assert property (@(posedge clk) disable iff (reset)
      (!hsync || !vsync) |-> rgb == 3'b000)
   else
   begin
      $error("rgb is not 000 while a sync pulse is active");
      rgb_bad = 1'b1;
   end

   sync_high_after_reset: assert property (@(posedge clk)
      $fell(reset) |-> hsync && vsync)
   else
   begin
      $error("sync outputs not high right after reset");
      rst_bad = 1'b1;
   end

endmodule

bind sprite_display_top sprite_display_assert u_assert (
   .clk   (clk),
   .reset (reset),
   .hsync (hsync),
   .vsync (vsync),
   .rgb   (rgb)
);

`default_nettype wire

// File: sprite_display_tb.sv
`default_nettype none

module sprite_display_tb;

   // ----------------------------------------------------------------------
   // scan geometry as seen on the VGA port
   // ----------------------------------------------------------------------
   localparam int LINE_CYCLES  = 800;
   localparam int FRAME_LINES  = 525;
   localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
   localparam int CLK_PERIOD   = 8;
   // slack past the frame of the last trace point
   localparam int SPARE_FRAMES = 2;
   // count word plus up to 64 entries of four words
   localparam int TRACE_WORDS  = 257;

   logic          clk;
   logic          reset;
   logic          hsync;
   logic          vsync;
   gfx_pkg::rgb_t rgb;

   logic [15:0]   trace_mem [0:TRACE_WORDS-1];
   int            n_entries;
   int            idx;
   int            pix;
   int            x;
   int            y;
   int            target;
   logic          exp_h;
   logic          exp_v;
   int            watchdog_limit = 0;

   tb_clock_gen u_clock (
      .clk   (clk),
      .reset (reset)
   );

   sprite_display_top DUT (
      .clk   (clk),
      .reset (reset),
      .hsync (hsync),
      .vsync (vsync),
      .rgb   (rgb)
   );

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic check_rgb(input gfx_pkg::rgb_t got, input gfx_pkg::rgb_t exp,
                            input string what);
      if (got !== exp)
      begin
         $display("mismatch at %0t: %s, rgb is %b, expected %b", $time, what, got, exp);
         $display("sim failed");
         $fatal(1, "stopping on first error");
      end
   endtask

   task automatic check_sync(input logic got_h, input logic got_v, input logic exp_hs,
                             input logic exp_vs, input string what);
      if (got_h !== exp_hs || got_v !== exp_vs)
      begin
         $display("mismatch at %0t: %s, hsync/vsync are %b/%b, expected %b/%b",
                  $time, what, got_h, got_v, exp_hs, exp_vs);
         $display("sim failed");
         $fatal(1, "stopping on first error");
      end
   endtask

   // scan cycle whose colour a trace entry samples
   function automatic int entry_pixel(input int i);
      int base;
      base = 4 * i + 1;
      entry_pixel = int'(trace_mem[base]) * FRAME_CYCLES +
                    int'(trace_mem[base + 2]) * LINE_CYCLES +
                    int'(trace_mem[base + 1]);
   endfunction

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      $readmemh("sprite_trace.txt", trace_mem);
      n_entries = int'(trace_mem[0]);
      if (n_entries < 1 || 4 * n_entries + 1 > TRACE_WORDS)
      begin
         $display("trace file is missing or gives a bad entry count");
         $display("sim failed");
         $fatal(1, "bad trace file");
      end
      // frame field of the last entry sets the run length
      watchdog_limit = (int'(trace_mem[4 * n_entries - 3]) + SPARE_FRAMES) *
                       FRAME_CYCLES * CLK_PERIOD;

      @(negedge reset);
      // no rising edge yet, outputs still hold reset values
      check_sync(hsync, vsync, 1'b1, 1'b1, "right after reset");
      check_rgb(rgb, 3'b000, "right after reset");

      pix = 0;
      idx = 0;
      while (idx < n_entries)
      begin
         @(negedge clk);
         // rgb now carries scan cycle pix, registered on the last rising edge
         x = pix % LINE_CYCLES;
         y = (pix / LINE_CYCLES) % FRAME_LINES;
         // active-low sync windows
         exp_h = !(x >= 656 && x <= 751);
         exp_v = !(y == 490 || y == 491);
         check_sync(hsync, vsync, exp_h, exp_v, "sync window");
         if (x >= 640 || y >= 480)
         begin
            check_rgb(rgb, 3'b000, "blanking");
         end
         target = entry_pixel(idx);
         if (target < pix)
         begin
            $display("trace entry %0d is not in scan order", idx);
            $display("sim failed");
            $fatal(1, "bad trace order");
         end
         else if (target == pix)
         begin
            check_rgb(rgb, trace_mem[4 * idx + 4][2:0], "trace point");
            idx = idx + 1;
         end
         pix = pix + 1;
      end

      $display("sim passed");
      $finish;
   end

   // stops on the first failed property of the bound checker
   initial
   begin
      wait (DUT.u_assert.any_failed === 1'b1);
      $display("an assertion on the VGA port failed at %0t", $time);
      $display("sim failed");
      $fatal(1, "assertion failure");
   end

   // watchdog, armed once the trace length is known
   initial
   begin
      wait (watchdog_limit > 0);
      #(watchdog_limit);
      $display("run timed out before the last trace point was reached");
      $display("sim failed");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

// File: sprite_display_top.sv
`default_nettype none

module sprite_display_top (
   input  logic          clk,
   input  logic          reset,
   output logic          hsync,
   output logic          vsync,
   output gfx_pkg::rgb_t rgb
);

   // shared scan position
   scan_if scan_bus ();

   logic hsync_raw;
   logic vsync_raw;
   logic logo_on;
   logic ball_on;

   // ----------------------------------------------------------------------
   // scan and objects
   // ----------------------------------------------------------------------
   vga_scan_gen u_scan (
      .clk       (clk),
      .reset     (reset),
      .scan      (scan_bus.source),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw)
   );

   logo_gen u_logo (
      .scan    (scan_bus.sink),
      .logo_on (logo_on)
   );

   ball_gen u_ball (
      .clk     (clk),
      .reset   (reset),
      .scan    (scan_bus.sink),
      .ball_on (ball_on)
   );

   // output stage
   pixel_mixer u_mixer (
      .clk       (clk),
      .reset     (reset),
      .scan      (scan_bus.sink),
      .logo_on   (logo_on),
      .ball_on   (ball_on),
      .hsync_raw (hsync_raw),
      .vsync_raw (vsync_raw),
      .rgb       (rgb),
      .hsync     (hsync),
      .vsync     (vsync)
   );

endmodule

`default_nettype wire

// File: sprite_trace.txt
// sampled pixels, all fields hex
// first word is the entry count, then one entry per line: frame x y rgb
23
// frame 0, background corner and ball at (320,4)
0 000 000 1
0 13F 007 1
0 140 007 6
// logo row 0 and ball row 6 side by side
0 139 00A 1
0 13A 00A 5
0 140 00A 1
0 141 00A 6
// logo row 1 and ball row 7
0 13F 00B 5
0 140 00B 1
0 142 00B 6
// logo body
0 137 00C 5
0 13B 00C 1
0 134 010 1
0 135 010 5
0 12C 019 1
0 13A 019 5
0 27F 1DF 1
// frames 1 to 3, ball climbs to the right
1 140 006 1
1 141 006 6
2 141 005 1
2 142 005 6
3 142 004 1
3 143 004 6
3 13A 00A 5
// frame 4, ball on the top edge
4 146 000 6
4 143 003 1
4 144 003 6
// frame 5, bounced down to y 1
5 145 000 1
5 144 004 1
5 145 004 6
// frame 6, logo unchanged
6 147 001 1
6 145 005 1
6 146 005 6
6 134 010 1
6 135 010 5

// File: tb_clock_gen.sv
`default_nettype none

// pixel clock and power-on reset for the testbench
module tb_clock_gen (
   output logic clk,
   output logic reset
);

   localparam int HALF_PERIOD  = 4;
   localparam int RESET_CYCLES = 5;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // reset released on a falling edge, away from the DUT's sampling edge
   initial
   begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire

// File: vga_scan_gen.sv
`default_nettype none

module vga_scan_gen (
   input  logic   clk,
   input  logic   reset,
   scan_if.source scan,
   output logic   hsync_raw,
   output logic   vsync_raw
);

   vga_timing_pkg::coord_t h_cnt;
   vga_timing_pkg::coord_t v_cnt;
   vga_timing_pkg::coord_t h_next;
   vga_timing_pkg::coord_t v_next;
   logic                   h_last;
   logic                   v_last;

   // ----------------------------------------------------------------------
   // next counter values
   // ----------------------------------------------------------------------
   assign h_last = (h_cnt == vga_timing_pkg::H_TOTAL - 10'd1);
   assign v_last = (v_cnt == vga_timing_pkg::V_TOTAL - 10'd1);

   // column wraps every line
   assign h_next = h_last ? '0 : h_cnt + 10'd1;

   // line advances only at the end of a line
   always_comb
   begin
      v_next = v_cnt;
      if (h_last)
      begin
         v_next = v_last ? '0 : v_cnt + 10'd1;
      end
   end

   // ----------------------------------------------------------------------
   // registers
   // ----------------------------------------------------------------------
   // decodes are taken from the next count so they line up with pix_x/pix_y
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         h_cnt          <= '0;
         v_cnt          <= '0;
         // position (0,0) is visible
         scan.video_on  <= 1'b1;
         scan.refr_tick <= 1'b0;
         hsync_raw      <= 1'b1;
         vsync_raw      <= 1'b1;
      end
      else
      begin
         h_cnt          <= h_next;
         v_cnt          <= v_next;
         scan.video_on  <= (h_next < vga_timing_pkg::H_DISPLAY) &&
                           (v_next < vga_timing_pkg::V_DISPLAY);
         scan.refr_tick <= (h_next == '0) && (v_next == vga_timing_pkg::REFR_LINE);
         // active-low sync pulses
         hsync_raw      <= !((h_next >= vga_timing_pkg::H_SYNC_START) &&
                             (h_next <= vga_timing_pkg::H_SYNC_END));
         vsync_raw      <= !((v_next >= vga_timing_pkg::V_SYNC_START) &&
                             (v_next <= vga_timing_pkg::V_SYNC_END));
      end
   end

   // scan position is the counter itself
   assign scan.pix_x = h_cnt;
   assign scan.pix_y = v_cnt;

endmodule

`default_nettype wire

// File: vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

   // screen coordinate, wide enough for the 800 x 525 frame
   typedef logic [9:0] coord_t;

   // ----------------------------------------------------------------------
   // horizontal timing, in pixel clocks
   // ----------------------------------------------------------------------
   localparam coord_t H_DISPLAY    = 10'd640;
   // sync window, both ends inclusive
   localparam coord_t H_SYNC_START = 10'd656;
   localparam coord_t H_SYNC_END   = 10'd751;
   localparam coord_t H_TOTAL      = 10'd800;

   // ----------------------------------------------------------------------
   // vertical timing, in lines
   // ----------------------------------------------------------------------
   localparam coord_t V_DISPLAY    = 10'd480;
   localparam coord_t V_SYNC_START = 10'd490;
   localparam coord_t V_SYNC_END   = 10'd491;
   localparam coord_t V_TOTAL      = 10'd525;

   // refresh strobe fires at column 0 of this line
   // below the visible area, so objects move off screen
   localparam coord_t REFR_LINE    = 10'd481;

endpackage

`default_nettype wire
